/* verilog/eth_rx_pkg.sv */
// Ethernet receive path definitions
// Stream and timestamp widths, FIFO depths and the stored beat layout
`default_nettype none

package eth_rx_pkg;

    // Byte stream from the MAC
    localparam int data_width = 8;

    // PTP timestamp, 48-bit seconds, 32-bit ns, 16-bit fractional ns
    localparam int ts_width = 96;

    // Frame FIFO storage
    localparam int frame_depth      = 64;
    localparam int frame_addr_width = 6;

    // Timestamp FIFO storage
    localparam int ts_depth      = 4;
    localparam int ts_addr_width = 2;

    // One beat as held in the frame FIFO memory
    typedef struct packed {
        logic [ts_width-1:0]   ts;
        logic                  last;
        logic [data_width-1:0] data;
    } rx_beat_t;

endpackage

`default_nettype wire

/* verilog/rx_frame_fifo.sv */
// Store-and-forward receive frame FIFO
// Holds each frame until its last beat, drops bad frames and frames
// that do not fit, and pulses good, bad and overflow status strobes
`default_nettype none

module rx_frame_fifo (
    input  wire                                 logic_clk,
    input  wire                                 logic_rst,
    input  wire  [eth_rx_pkg::data_width-1:0]   mac_rx_data,
    input  wire                                 mac_rx_valid,
    input  wire                                 mac_rx_last,
    input  wire                                 mac_rx_bad,
    input  wire  [eth_rx_pkg::ts_width-1:0]     mac_rx_ts,
    input  wire                                 rx_ready,
    output logic [eth_rx_pkg::data_width-1:0]   rx_data,
    output logic                                rx_valid,
    output logic                                rx_last,
    output logic [eth_rx_pkg::ts_width-1:0]     rx_ts,
    output logic                                good_frame,
    output logic                                bad_frame,
    output logic                                overflow
);

    // Pointers carry one extra bit to tell full from empty
    logic [eth_rx_pkg::frame_addr_width:0] wr_ptr;
    logic [eth_rx_pkg::frame_addr_width:0] commit_ptr;
    logic [eth_rx_pkg::frame_addr_width:0] rd_ptr;
    logic [eth_rx_pkg::frame_addr_width:0] rd_ptr_next;
    logic [eth_rx_pkg::frame_addr_width:0] used;

    eth_rx_pkg::rx_beat_t mem [eth_rx_pkg::frame_depth];
    eth_rx_pkg::rx_beat_t head;

    logic drop_frame;
    logic full;
    logic reject;
    logic wr_en;
    logic rx_xfer;

    // Entries held, counting the current frame's earlier beats
    assign used = wr_ptr - rd_ptr;
    assign full = (used == (eth_rx_pkg::frame_addr_width + 1)'(eth_rx_pkg::frame_depth));

    // Once a frame has hit a full FIFO, the rest of it is discarded
    assign reject = full || drop_frame;
    assign wr_en  = mac_rx_valid && !reject;

    assign rx_xfer     = rx_valid && rx_ready;
    assign rd_ptr_next = rx_xfer ? rd_ptr + 1'b1 : rd_ptr;

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[eth_rx_pkg::frame_addr_width-1:0]] <= '{
                ts:   mac_rx_ts,
                last: mac_rx_last,
                data: mac_rx_data
            };
        end
    end

    // Head entry drives the output stream directly
    assign head    = mem[rd_ptr[eth_rx_pkg::frame_addr_width-1:0]];
    assign rx_data = head.data;
    assign rx_last = head.last;
    assign rx_ts   = head.ts;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            rx_valid   <= 1'b0;
            drop_frame <= 1'b0;
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;

            rd_ptr <= rd_ptr_next;
            // Valid follows committed data one cycle behind the commit
            rx_valid <= (rd_ptr_next != commit_ptr);

            if (mac_rx_valid) begin
                if (mac_rx_last) begin
                    drop_frame <= 1'b0;
                    if (reject) begin
                        // Overflow wins over a bad flag on the same frame
                        overflow <= 1'b1;
                        wr_ptr   <= commit_ptr;
                    end else if (mac_rx_bad) begin
                        bad_frame <= 1'b1;
                        wr_ptr    <= commit_ptr;
                    end else begin
                        good_frame <= 1'b1;
                        wr_ptr     <= wr_ptr + 1'b1;
                        commit_ptr <= wr_ptr + 1'b1;
                    end
                end else if (reject) begin
                    drop_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // Frame end gives at most one status
    a_one_strobe: assert property (@(posedge logic_clk) disable iff (logic_rst)
        $onehot0({good_frame, bad_frame, overflow}));

    // Output never runs ahead of committed frames
    a_valid_committed: assert property (@(posedge logic_clk) disable iff (logic_rst)
        rx_valid |-> (rd_ptr != commit_ptr));

endmodule

`default_nettype wire

/* verilog/ptp_ts_extract.sv */
// PTP timestamp extractor
// Captures the timestamp carried on the first delivered beat of each frame
`default_nettype none

module ptp_ts_extract (
    input  wire                               logic_clk,
    input  wire                               logic_rst,
    input  wire                               rx_valid,
    input  wire                               rx_ready,
    input  wire                               rx_last,
    input  wire  [eth_rx_pkg::ts_width-1:0]   rx_ts,
    output logic [eth_rx_pkg::ts_width-1:0]   cap_ts,
    output logic                              cap_valid
);

    logic xfer;
    logic first_beat;

    assign xfer = rx_valid && rx_ready;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            first_beat <= 1'b1;
            cap_valid  <= 1'b0;
        end else begin
            cap_valid <= xfer && first_beat;
            // Next frame starts right after a last beat
            if (xfer) begin
                first_beat <= rx_last;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (xfer && first_beat) begin
            cap_ts <= rx_ts;
        end
    end

endmodule

`default_nettype wire

/* verilog/ts_fifo.sv */
// Receive timestamp FIFO
// Small first-word-fall-through queue, writes are lost while it is full
`default_nettype none

module ts_fifo (
    input  wire                               logic_clk,
    input  wire                               logic_rst,
    input  wire  [eth_rx_pkg::ts_width-1:0]   cap_ts,
    input  wire                               cap_valid,
    input  wire                               ts_ready,
    output logic [eth_rx_pkg::ts_width-1:0]   ts,
    output logic                              ts_valid
);

    logic [eth_rx_pkg::ts_width-1:0] mem [eth_rx_pkg::ts_depth];

    logic [eth_rx_pkg::ts_addr_width-1:0] wr_ptr;
    logic [eth_rx_pkg::ts_addr_width-1:0] rd_ptr;
    logic [eth_rx_pkg::ts_addr_width:0]   count;
    logic                                 wr_en;
    logic                                 rd_en;

    // No back-pressure to the extractor, a full queue just ignores it
    assign wr_en = cap_valid && (count != (eth_rx_pkg::ts_addr_width + 1)'(eth_rx_pkg::ts_depth));
    assign rd_en = ts_valid && ts_ready;

    assign ts_valid = (count != '0);
    assign ts       = mem[rd_ptr];

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= cap_ts;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (@(posedge logic_clk) disable iff (logic_rst)
        count <= (eth_rx_pkg::ts_addr_width + 1)'(eth_rx_pkg::ts_depth));

endmodule

`default_nettype wire

/* verilog/eth_rx_logic_top.sv */
// Ethernet receive path top level
// Frame FIFO with status, plus per-frame PTP timestamp capture and queue
`default_nettype none

module eth_rx_logic_top (
    input  wire                               logic_clk,
    input  wire                               logic_rst,
    input  wire  [eth_rx_pkg::data_width-1:0] mac_rx_data,
    input  wire                               mac_rx_valid,
    input  wire                               mac_rx_last,
    input  wire                               mac_rx_bad,
    input  wire  [eth_rx_pkg::ts_width-1:0]   mac_rx_ts,
    input  wire                               rx_ready,
    input  wire                               ts_ready,
    output logic [eth_rx_pkg::data_width-1:0] rx_data,
    output logic                              rx_valid,
    output logic                              rx_last,
    output logic [eth_rx_pkg::ts_width-1:0]   ts,
    output logic                              ts_valid,
    output logic                              good_frame,
    output logic                              bad_frame,
    output logic                              overflow
);

    // Timestamp of the head beat
    logic [eth_rx_pkg::ts_width-1:0] rx_ts;

    // Captured first-beat timestamp
    logic [eth_rx_pkg::ts_width-1:0] cap_ts;
    logic                            cap_valid;

    rx_frame_fifo frame_fifo (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .mac_rx_data  (mac_rx_data),
        .mac_rx_valid (mac_rx_valid),
        .mac_rx_last  (mac_rx_last),
        .mac_rx_bad   (mac_rx_bad),
        .mac_rx_ts    (mac_rx_ts),
        .rx_ready     (rx_ready),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_last      (rx_last),
        .rx_ts        (rx_ts),
        .good_frame   (good_frame),
        .bad_frame    (bad_frame),
        .overflow     (overflow)
    );

    ptp_ts_extract ts_extract (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .rx_last   (rx_last),
        .rx_ts     (rx_ts),
        .cap_ts    (cap_ts),
        .cap_valid (cap_valid)
    );

    ts_fifo ts_queue (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .cap_ts    (cap_ts),
        .cap_valid (cap_valid),
        .ts_ready  (ts_ready),
        .ts        (ts),
        .ts_valid  (ts_valid)
    );

endmodule

`default_nettype wire

/* test/tb_eth_rx_logic.sv */
// Testbench for the Ethernet receive path
// Random frames checked against a queue model of the frame and timestamp FIFOs
`default_nettype none

module tb_eth_rx_logic;

    localparam int max_len      = 20;
    localparam int mixed_frames = 40;
    localparam int after_frames = 6;
    localparam int max_gap      = 3;
    // One entry per frame at worst before the stalled FIFO fills
    localparam int fill_frames  = eth_rx_pkg::frame_depth + 1;
    localparam int stim_beats   = (mixed_frames + fill_frames + 2 * after_frames) * max_len;
    localparam int idle_cycles  = (mixed_frames + after_frames) * max_gap + 6 * 200;
    localparam int cycle_limit  = 4 * (stim_beats + idle_cycles);

    logic                              logic_clk;
    logic                              logic_rst;
    logic [eth_rx_pkg::data_width-1:0] mac_rx_data;
    logic                              mac_rx_valid;
    logic                              mac_rx_last;
    logic                              mac_rx_bad;
    logic [eth_rx_pkg::ts_width-1:0]   mac_rx_ts;
    logic                              rx_ready;
    logic                              ts_ready;
    logic [eth_rx_pkg::data_width-1:0] rx_data;
    logic                              rx_valid;
    logic                              rx_last;
    logic [eth_rx_pkg::ts_width-1:0]   ts;
    logic                              ts_valid;
    logic                              good_frame;
    logic                              bad_frame;
    logic                              overflow;

    // Model state, bytes carry the last flag above the data
    logic [eth_rx_pkg::data_width:0] cur_frame [$];
    logic [eth_rx_pkg::data_width:0] exp_bytes [$];
    logic [eth_rx_pkg::ts_width-1:0] exp_frame_ts [$];
    logic [eth_rx_pkg::ts_width-1:0] exp_ts_q [$];
    logic [eth_rx_pkg::ts_width-1:0] cap_ts_pending;
    logic cap_pending;
    logic dropping;
    logic first_out;
    logic exp_good;
    logic exp_bad;
    logic exp_ovf;
    logic ts_open;
    int   stored;
    int   cur_written;
    int   last_fate;
    int   ready_mode;
    int   frames_out;
    int   ts_reads;
    int   start_reads;
    int   ovf_seen;
    int   data_errors;
    int   status_errors;
    int   ts_errors;
    int   other_errors;
    int   cycle_count;
    integer seed;

    eth_rx_logic_top dut (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .mac_rx_data  (mac_rx_data),
        .mac_rx_valid (mac_rx_valid),
        .mac_rx_last  (mac_rx_last),
        .mac_rx_bad   (mac_rx_bad),
        .mac_rx_ts    (mac_rx_ts),
        .rx_ready     (rx_ready),
        .ts_ready     (ts_ready),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_last      (rx_last),
        .ts           (ts),
        .ts_valid     (ts_valid),
        .good_frame   (good_frame),
        .bad_frame    (bad_frame),
        .overflow     (overflow)
    );

    always #20 logic_clk = ~logic_clk;

    always @(posedge logic_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Strobes belong to the last beat presented one cycle earlier
    task automatic check_strobes();
        if (good_frame !== exp_good) begin
            status_errors++;
            $display("[ERROR] good_frame expected %h got %h", exp_good, good_frame);
        end
        if (bad_frame !== exp_bad) begin
            status_errors++;
            $display("[ERROR] bad_frame expected %h got %h", exp_bad, bad_frame);
        end
        if (overflow !== exp_ovf) begin
            status_errors++;
            $display("[ERROR] overflow expected %h got %h", exp_ovf, overflow);
        end
        if (overflow === 1'b1) begin
            ovf_seen++;
        end
        exp_good = 1'b0;
        exp_bad  = 1'b0;
        exp_ovf  = 1'b0;
    endtask

    // Timestamp queue, the head read and a capture write share one edge
    task automatic check_ts();
        logic [eth_rx_pkg::ts_width-1:0] head_ts;
        logic                            ts_full;
        if (ts_valid !== (exp_ts_q.size() != 0)) begin
            ts_errors++;
            $display("[ERROR] ts_valid expected %h got %h", exp_ts_q.size() != 0, ts_valid);
        end
        ts_full = (exp_ts_q.size() == eth_rx_pkg::ts_depth);
        if (ts_valid === 1'b1 && ts_ready) begin
            ts_reads++;
            if (exp_ts_q.size() != 0) begin
                head_ts = exp_ts_q.pop_front();
                if (ts !== head_ts) begin
                    ts_errors++;
                    $display("[ERROR] ts expected %h got %h", head_ts, ts);
                end
            end
        end
        if (cap_pending && !ts_full) begin
            exp_ts_q.push_back(cap_ts_pending);
        end
        cap_pending = 1'b0;
    endtask

    // One falling edge: check outputs, drive inputs, update the model
    task automatic step(input logic valid, input logic [eth_rx_pkg::data_width-1:0] data,
                        input logic last, input logic bad,
                        input logic [eth_rx_pkg::ts_width-1:0] frame_ts);
        logic [eth_rx_pkg::data_width:0] head;
        logic                            reject;
        logic                            xfer;
        @(negedge logic_clk);
        ts_ready = ts_open;
        check_strobes();
        check_ts();
        case (ready_mode)
            0:       rx_ready = 1'b0;
            1:       rx_ready = 1'b1;
            default: rx_ready = (($random(seed) & 3) != 0);
        endcase
        xfer = rx_valid && rx_ready;

        mac_rx_valid = valid;
        mac_rx_data  = data;
        mac_rx_last  = last;
        mac_rx_bad   = bad;
        mac_rx_ts    = frame_ts;
        // Space is judged before this edge's read leaves
        if (valid) begin
            reject = (stored == eth_rx_pkg::frame_depth) || dropping;
            if (last) begin
                if (reject) begin
                    exp_ovf   = 1'b1;
                    last_fate = 2;
                    stored    = stored - cur_written;
                end else if (bad) begin
                    exp_bad   = 1'b1;
                    last_fate = 1;
                    stored    = stored - cur_written;
                end else begin
                    exp_good  = 1'b1;
                    last_fate = 0;
                    stored    = stored + 1;
                    foreach (cur_frame[i]) exp_bytes.push_back(cur_frame[i]);
                    exp_frame_ts.push_back(frame_ts);
                end
                cur_written = 0;
                dropping    = 1'b0;
            end else if (reject) begin
                dropping = 1'b1;
            end else begin
                stored      = stored + 1;
                cur_written = cur_written + 1;
            end
        end

        if (xfer) begin
            stored = stored - 1;
            if (exp_bytes.size() == 0) begin
                other_errors++;
                $display("An output beat was taken while no committed frame was left");
            end else begin
                head = exp_bytes.pop_front();
                if (rx_data !== head[eth_rx_pkg::data_width-1:0]) begin
                    data_errors++;
                    $display("[ERROR] rx_data expected %h got %h",
                             head[eth_rx_pkg::data_width-1:0], rx_data);
                end
                if (rx_last !== head[eth_rx_pkg::data_width]) begin
                    data_errors++;
                    $display("[ERROR] rx_last expected %h got %h",
                             head[eth_rx_pkg::data_width], rx_last);
                end
                if (first_out) begin
                    cap_pending    = 1'b1;
                    cap_ts_pending = exp_frame_ts.pop_front();
                    frames_out++;
                end
                first_out = head[eth_rx_pkg::data_width];
            end
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) step(1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic send_frame(input int len, input logic bad);
        logic [eth_rx_pkg::ts_width-1:0]   frame_ts;
        logic [eth_rx_pkg::data_width-1:0] b;
        frame_ts = {$random(seed), $random(seed), $random(seed)};
        cur_frame.delete();
        for (int i = 0; i < len; i++) begin
            b = 8'($random(seed));
            cur_frame.push_back({i == len - 1, b});
        end
        for (int i = 0; i < len; i++) begin
            step(1'b1, cur_frame[i][eth_rx_pkg::data_width-1:0],
                 cur_frame[i][eth_rx_pkg::data_width], bad && (i == len - 1), frame_ts);
        end
    endtask

    function automatic int random_len();
        random_len = 1 + (($random(seed) & 32'h7fff_ffff) % max_len);
    endfunction

    // Let every committed frame and captured timestamp leave
    task automatic drain();
        ready_mode = 1;
        while (exp_bytes.size() != 0 || cap_pending || (ts_open && exp_ts_q.size() != 0)) begin
            idle(1);
        end
        idle(4);
        if (rx_valid !== 1'b0) begin
            other_errors++;
            $display("rx_valid is still high after all frames left");
        end
    endtask

    initial begin
        seed          = 69;
        logic_clk     = 1'b0;
        logic_rst     = 1'b1;
        mac_rx_data   = '0;
        mac_rx_valid  = 1'b0;
        mac_rx_last   = 1'b0;
        mac_rx_bad    = 1'b0;
        mac_rx_ts     = '0;
        rx_ready      = 1'b0;
        ts_ready      = 1'b1;
        ts_open       = 1'b1;
        cap_pending   = 1'b0;
        dropping      = 1'b0;
        first_out     = 1'b1;
        exp_good      = 1'b0;
        exp_bad       = 1'b0;
        exp_ovf       = 1'b0;
        stored        = 0;
        cur_written   = 0;
        last_fate     = 0;
        ready_mode    = 2;
        frames_out    = 0;
        ts_reads      = 0;
        ovf_seen      = 0;
        data_errors   = 0;
        status_errors = 0;
        ts_errors     = 0;
        other_errors  = 0;
        cycle_count   = 0;
        repeat (3) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;

        // Mixed good and bad frames under random back-pressure
        for (int f = 0; f < mixed_frames; f++) begin
            send_frame(random_len(), ($random(seed) & 3) == 0);
            idle($random(seed) & max_gap);
        end
        drain();
        if (ts_reads != frames_out) begin
            other_errors++;
            $display("Read %0d timestamps for %0d delivered frames", ts_reads, frames_out);
        end

        // Stalled output until a frame no longer fits
        ready_mode = 0;
        last_fate  = 0;
        ovf_seen   = 0;
        for (int f = 0; f < fill_frames && last_fate != 2; f++) begin
            send_frame(random_len(), 1'b0);
        end
        drain();
        if (ovf_seen != 1) begin
            other_errors++;
            $display("Saw %0d overflow strobes while the output was stalled instead of 1",
                     ovf_seen);
        end
        ready_mode = 2;
        for (int f = 0; f < after_frames; f++) begin
            send_frame(random_len(), 1'b0);
        end
        drain();

        // Timestamp queue held while more frames than it holds go out
        ts_open     = 1'b0;
        start_reads = ts_reads;
        for (int f = 0; f < after_frames; f++) begin
            send_frame(random_len(), 1'b0);
        end
        drain();
        ts_open = 1'b1;
        drain();
        if (ts_reads - start_reads != eth_rx_pkg::ts_depth) begin
            other_errors++;
            $display("Read %0d timestamps after the stall instead of %0d",
                     ts_reads - start_reads, eth_rx_pkg::ts_depth);
        end

        $display("Errors: data %0d, status %0d, timestamp %0d, other %0d",
                 data_errors, status_errors, ts_errors, other_errors);
        if (data_errors + status_errors + ts_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/eth_rx_pkg.sv
verilog/rx_frame_fifo.sv
verilog/ptp_ts_extract.sv
verilog/ts_fifo.sv
verilog/eth_rx_logic_top.sv
test/tb_eth_rx_logic.sv

/* run.sh */
#!/bin/sh
# Build and run the receive path simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_eth_rx_logic \
    -Mdir obj_dir -o sim -f src.f

out=$(./obj_dir/sim)
echo "$out"
echo "$out" | grep -q '\*\*\* PASSED \*\*\*'
